//--- common/ifetch_pkg.sv
// Widths fixed at 32 bit, addresses word aligned, counters sized for depths of at most 8
`default_nettype none

package ifetch_pkg;

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////

  // Byte address, bits 1:0 always zero
  typedef logic [31:0] addr_t;

  // One uncompressed instruction word
  typedef logic [31:0] instr_t;

  // FIFO occupancy and bus outstanding count
  typedef logic [3:0] cnt_t;

  // Prefetch controller states
  typedef enum logic [0:0] {
    IDLE,
    BRANCH_WAIT
  } prefetch_state_e;

  //////////////////////////////////////////////////
  // Bundled payloads
  //////////////////////////////////////////////////

  // Request payload, qualified by bus req
  typedef struct packed {
    addr_t addr;
  } obi_req_t;

  // Response payload, qualified by bus rvalid
  typedef struct packed {
    instr_t rdata;
    logic   err;
  } obi_rsp_t;

  // Word handed to decode, also the FIFO entry
  typedef struct packed {
    addr_t  addr;
    instr_t rdata;
    logic   err;
  } fetch_out_t;

endpackage

`default_nettype wire

//--- prefetch/ifetch_prefetch_ctrl.sv
// First request after reset must be a branch; FIFO_DEPTH must match the FIFO and be >= MAX_OUTSTANDING
`timescale 1ns/1ps
`default_nettype none

module ifetch_prefetch_ctrl #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  // Fetch stage
  input  logic              fetch_enable_i,
  input  logic              branch_i,
  input  ifetch_pkg::addr_t branch_addr_i,
  // Occupancy from FIFO and adapter
  input  ifetch_pkg::cnt_t  fifo_cnt_i,
  input  ifetch_pkg::cnt_t  outstanding_i,
  // Transaction request to adapter
  output logic              trans_valid_o,
  input  logic              trans_ready_i,
  output ifetch_pkg::addr_t trans_addr_o
);

  import ifetch_pkg::*;

  prefetch_state_e state_q, state_d;

  // Next address to request
  addr_t addr_q, addr_d;

  // Set until the first accepted request
  logic  first_fetch_q;

  // Words in FIFO plus words still on their way
  cnt_t  occupied;
  logic  space;
  logic  accept;

  // Last accepted address for the increment check
  addr_t acc_addr_q;

  assign occupied = fifo_cnt_i + outstanding_i;
  assign space    = occupied < cnt_t'(FIFO_DEPTH);
  assign accept   = trans_valid_o && trans_ready_i;

  //////////////////////////////////////////////////
  // Request and next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    addr_d        = addr_q;
    trans_valid_o = 1'b0;
    trans_addr_o  = addr_q;

    if (branch_i) begin
      // Branch target goes out in the same cycle
      // Old stream is flushed and dropped so the target needs no free slot
      trans_valid_o = 1'b1;
      trans_addr_o  = branch_addr_i;
      if (trans_ready_i) begin
        addr_d  = branch_addr_i + 32'd4;
        state_d = IDLE;
      end else begin
        addr_d  = branch_addr_i;
        state_d = BRANCH_WAIT;
      end
    end else if (state_q == BRANCH_WAIT) begin
      // Hold the target until the bus takes it
      trans_valid_o = 1'b1;
      if (trans_ready_i) begin
        addr_d  = addr_q + 32'd4;
        state_d = IDLE;
      end
    end else begin
      // Sequential stream only after the first branch
      trans_valid_o = fetch_enable_i && space && !first_fetch_q;
      if (trans_valid_o && trans_ready_i) begin
        addr_d = addr_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      addr_q        <= '0;
      first_fetch_q <= 1'b1;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      if (accept) begin
        first_fetch_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_addr_q <= '0;
    end else if (accept) begin
      acc_addr_q <= trans_addr_o;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Without enable only a branch target held from an unaccepted request
  a_trans_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (trans_valid_o && !fetch_enable_i && !branch_i)
      |-> ($past(trans_valid_o && !trans_ready_i) && trans_addr_o == $past(trans_addr_o)))
    else $error("trans_valid_o without fetch_enable_i or pending branch");

  // Target visible on the bus address in the branch cycle
  a_branch_addr: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> (trans_valid_o && trans_addr_o == branch_addr_i))
    else $error("branch address not on trans_addr_o");

  a_branch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> (branch_addr_i[1:0] == 2'b00))
    else $error("branch_addr_i not word aligned");

  a_trans_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    trans_valid_o |-> (trans_addr_o[1:0] == 2'b00))
    else $error("trans_addr_o not word aligned");

  // Sequential requests follow the last accepted one by a word
  a_addr_incr: assert property (@(posedge clk) disable iff (!rst_n)
    (trans_valid_o && !branch_i && state_q == IDLE && !first_fetch_q)
      |-> (trans_addr_o == acc_addr_q + 32'd4))
    else $error("sequential address is not previous plus 4");

  // Nothing goes out after reset until the fetch stage branches
  a_first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    (first_fetch_q && accept) |-> (branch_i || state_q == BRANCH_WAIT))
    else $error("first fetch after reset is not a branch");

endmodule

`default_nettype wire

//--- prefetch/ifetch_instr_fifo.sv
// Depth 2 to 8; flush wins over a push in the same cycle; caller must never push while full
`timescale 1ns/1ps
`default_nettype none

module ifetch_instr_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  // Write side from the bus adapter
  input  logic                   push_i,
  input  ifetch_pkg::fetch_out_t push_data_i,
  // Read side towards decode
  output logic                   pop_valid_o,
  output ifetch_pkg::fetch_out_t pop_data_o,
  input  logic                   pop_ready_i,
  output ifetch_pkg::cnt_t       count_o
);

  import ifetch_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

  fetch_out_t       mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  cnt_t             count_q;

  logic do_push;
  logic do_pop;

  // Flushed words are gone the same cycle
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_valid_o && pop_ready_i && !flush_i;

  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem_q[rd_ptr_q];
  assign count_o     = count_q;

  //////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      count_q <= count_q + cnt_t'(do_push) - cnt_t'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Space check upstream keeps pushes within depth
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    do_push |-> (count_q < cnt_t'(FIFO_DEPTH) || do_pop))
    else $error("instruction FIFO pushed while full");

endmodule

`default_nettype wire

//--- source/ifetch_obi_adapter.sv
// Memory returns responses in grant order and never earlier than one cycle after the grant
`timescale 1ns/1ps
`default_nettype none

module ifetch_obi_adapter #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   branch_i,
  // Transaction side from the controller
  input  logic                   trans_valid_i,
  output logic                   trans_ready_o,
  input  ifetch_pkg::addr_t      trans_addr_i,
  // OBI request
  output logic                   bus_req_o,
  input  logic                   bus_gnt_i,
  output ifetch_pkg::obi_req_t   bus_req_data_o,
  // OBI response
  input  logic                   bus_rvalid_i,
  input  ifetch_pkg::obi_rsp_t   bus_rsp_i,
  // Towards the FIFO
  output logic                   push_o,
  output ifetch_pkg::fetch_out_t push_data_o,
  output ifetch_pkg::cnt_t       outstanding_o
);

  import ifetch_pkg::*;

  localparam int QPTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam logic [QPTR_W-1:0] QLAST = QPTR_W'(MAX_OUTSTANDING - 1);

  cnt_t  outstanding_q;
  cnt_t  discard_q;
  logic  room;
  logic  grant;
  logic  drop;

  // Address queue in grant order
  addr_t             aq_q [MAX_OUTSTANDING];
  logic [QPTR_W-1:0] aq_wr_q;
  logic [QPTR_W-1:0] aq_rd_q;

  // Registered response
  logic       push_q;
  fetch_out_t rsp_q;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  assign room                = outstanding_q < cnt_t'(MAX_OUTSTANDING);
  assign bus_req_o           = trans_valid_i && room;
  assign bus_req_data_o.addr = trans_addr_i;
  assign trans_ready_o       = bus_gnt_i && room;
  assign grant               = bus_req_o && bus_gnt_i;

  // Responses to an abandoned stream never reach the FIFO
  // Includes the one arriving in the branch cycle itself
  assign drop = bus_rvalid_i && (branch_i || discard_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      discard_q     <= '0;
      aq_wr_q       <= '0;
      aq_rd_q       <= '0;
      push_q        <= 1'b0;
    end else begin
      outstanding_q <= outstanding_q + cnt_t'(grant) - cnt_t'(bus_rvalid_i);
      if (branch_i) begin
        // Everything in flight before this edge belongs to the old stream
        discard_q <= outstanding_q - cnt_t'(bus_rvalid_i);
      end else if (drop) begin
        discard_q <= discard_q - 1'b1;
      end
      if (grant) begin
        aq_wr_q <= (aq_wr_q == QLAST) ? '0 : aq_wr_q + 1'b1;
      end
      if (bus_rvalid_i) begin
        aq_rd_q <= (aq_rd_q == QLAST) ? '0 : aq_rd_q + 1'b1;
      end
      push_q <= bus_rvalid_i && !drop;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (grant) begin
      aq_q[aq_wr_q] <= trans_addr_i;
    end
    if (bus_rvalid_i) begin
      rsp_q.addr  <= aq_q[aq_rd_q];
      rsp_q.rdata <= bus_rsp_i.rdata;
      rsp_q.err   <= bus_rsp_i.err;
    end
  end

  assign push_o      = push_q;
  assign push_data_o = rsp_q;

  // The word held in the response register still needs a FIFO slot
  assign outstanding_o = outstanding_q + cnt_t'(push_q);

  // In-order bus must never answer more than it granted
  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (outstanding_q != '0))
    else $error("bus response with nothing outstanding");

endmodule

`default_nettype wire

//--- source/ifetch_top.sv
// Fetch stage must branch before the first fetch; MAX_OUTSTANDING 1..4 and not above FIFO_DEPTH 2..8
`timescale 1ns/1ps
`default_nettype none

module ifetch_top #(
  parameter int FIFO_DEPTH      = 4,
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Fetch stage
  input  logic                   fetch_enable_i,
  input  logic                   branch_i,
  input  ifetch_pkg::addr_t      branch_addr_i,
  // Decode
  output logic                   instr_valid_o,
  output ifetch_pkg::fetch_out_t instr_o,
  input  logic                   instr_ready_i,
  // OBI bus
  output logic                   bus_req_o,
  output ifetch_pkg::obi_req_t   bus_req_data_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  ifetch_pkg::obi_rsp_t   bus_rsp_i
);

  import ifetch_pkg::*;

  // Controller to adapter
  logic       trans_valid;
  logic       trans_ready;
  addr_t      trans_addr;

  // Adapter to FIFO
  logic       push;
  fetch_out_t push_data;

  // Occupancy back to the controller
  cnt_t       fifo_cnt;
  cnt_t       outstanding;

  ifetch_prefetch_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_prefetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .fifo_cnt_i     (fifo_cnt),
    .outstanding_i  (outstanding),
    .trans_valid_o  (trans_valid),
    .trans_ready_i  (trans_ready),
    .trans_addr_o   (trans_addr)
  );

  ifetch_obi_adapter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_obi_adapter (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .trans_valid_i  (trans_valid),
    .trans_ready_o  (trans_ready),
    .trans_addr_i   (trans_addr),
    .bus_req_o      (bus_req_o),
    .bus_gnt_i      (bus_gnt_i),
    .bus_req_data_o (bus_req_data_o),
    .bus_rvalid_i   (bus_rvalid_i),
    .bus_rsp_i      (bus_rsp_i),
    .push_o         (push),
    .push_data_o    (push_data),
    .outstanding_o  (outstanding)
  );

  // Branch flushes buffered words of the old stream
  ifetch_instr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_instr_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_valid_o (instr_valid_o),
    .pop_data_o  (instr_o),
    .pop_ready_i (instr_ready_i),
    .count_o     (fifo_cnt)
  );

endmodule

`default_nettype wire

//--- test/tb_ifetch_mem.sv
// Bus memory model; random grant, in-order answers 1 to 3 cycles after grant, at most 16 in flight
`timescale 1ns/1ps
`default_nettype none

module tb_ifetch_mem #(
  parameter logic [31:0] SEED = 32'd95206
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  ifetch_pkg::obi_req_t req_data_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output ifetch_pkg::obi_rsp_t rsp_o
);

  import ifetch_pkg::*;

  localparam logic [31:0] DATA_KEY = 32'h5A3C_96E1;

  // Random state and the outputs for the coming cycle
  logic [31:0] rng_q    = SEED;
  logic [31:0] lat_q    = 32'd1;
  logic        gnt_q    = 1'b0;
  logic        rvalid_q = 1'b0;
  obi_rsp_t    rsp_q    = '0;

  // Granted requests in order, with the cycle each may answer
  addr_t       addr_q [16];
  logic [31:0] due_q  [16];
  logic [3:0]  head_q = 4'd0;
  logic [3:0]  tail_q = 4'd0;
  logic [31:0] cycle_q = 32'd0;

  assign gnt_o    = gnt_q;
  assign rvalid_o = rvalid_q;
  assign rsp_o    = rsp_q;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory contents as a function of the address
  function automatic obi_rsp_t rsp_for_addr(input addr_t a);
    obi_rsp_t r;
    r.rdata = a ^ DATA_KEY;
    r.err   = (a[31:28] == 4'hF);
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Grant capture on the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      tail_q  <= 4'd0;
      cycle_q <= 32'd0;
    end else begin
      if (req_i && gnt_o) begin
        addr_q[tail_q] <= req_data_i.addr;
        due_q[tail_q]  <= cycle_q + lat_q;
        tail_q         <= tail_q + 4'd1;
      end
      cycle_q <= cycle_q + 32'd1;
    end
  end

  //////////////////////////////////////////////////
  // Bus outputs on the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin : drive_bus
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = lcg_step(rng_q);
    r2 = lcg_step(r1);
    rng_q <= r2;
    if (!rst_n) begin
      head_q   <= 4'd0;
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      rsp_q    <= '0;
    end else begin
      // Grant about three cycles in four
      gnt_q <= (r1[31:30] != 2'b00);
      // Latency for a grant in the coming cycle
      lat_q <= 32'd1 + ((r2 >> 30) % 32'd3);
      // Oldest request answers once its time has come
      if (head_q != tail_q && due_q[head_q] <= cycle_q) begin
        rvalid_q <= 1'b1;
        rsp_q    <= rsp_for_addr(addr_q[head_q]);
        head_q   <= head_q + 4'd1;
      end else begin
        rvalid_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_ifetch.sv
// Runs FIFO_DEPTH 4 and MAX_OUTSTANDING 2; inputs change on the falling edge, checks on the rising
`timescale 1ns/1ps
`default_nettype none

module tb_ifetch;

  import ifetch_pkg::*;

  localparam int FIFO_DEPTH      = 4;
  localparam int MAX_OUTSTANDING = 2;
  localparam int NUM_WORDS       = 420;
  localparam int CYCLES_PER_WORD = 40;
  localparam int PERIOD_NS       = 4;
  localparam int TIMEOUT_NS      = NUM_WORDS * CYCLES_PER_WORD * PERIOD_NS;
  localparam logic [31:0] DATA_KEY = 32'h5A3C_96E1;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       fetch_enable;
  logic       branch;
  addr_t      branch_addr;
  logic       instr_valid;
  fetch_out_t instr;
  logic       instr_ready;
  logic       bus_req;
  obi_req_t   bus_req_data;
  logic       bus_gnt;
  logic       bus_rvalid;
  obi_rsp_t   bus_rsp;

  logic [31:0] rng_state = 32'd95206;

  // Reference model and bus bookkeeping
  addr_t      exp_addr       = '0;
  int         words          = 0;
  int         errors         = 0;
  int         in_flight      = 0;
  logic       branch_pending = 1'b0;
  logic       seen_branch    = 1'b0;
  logic       held           = 1'b0;
  fetch_out_t held_word      = '0;

  always #2 clk = ~clk;

  ifetch_top #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_ifetch_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .instr_valid_o  (instr_valid),
    .instr_o        (instr),
    .instr_ready_i  (instr_ready),
    .bus_req_o      (bus_req),
    .bus_req_data_o (bus_req_data),
    .bus_gnt_i      (bus_gnt),
    .bus_rvalid_i   (bus_rvalid),
    .bus_rsp_i      (bus_rsp)
  );

  tb_ifetch_mem #(
    .SEED (32'd95206)
  ) u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (bus_req),
    .req_data_i (bus_req_data),
    .gnt_o      (bus_gnt),
    .rvalid_o   (bus_rvalid),
    .rsp_o      (bus_rsp)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s at %0t: expected %08h, actual %08h", name, $time, exp, act);
    end
  endtask

  // One-cycle branch pulse from a falling edge
  task automatic jump_to(input addr_t target);
    branch      = 1'b1;
    branch_addr = target;
    @(negedge clk);
    branch      = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Monitor on the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      check_value("reset instr_valid", 32'd0, 32'(instr_valid));
      check_value("reset bus_req", 32'd0, 32'(bus_req));
      in_flight      = 0;
      branch_pending = 1'b0;
      seen_branch    = 1'b0;
      held           = 1'b0;
    end else begin
      // Nothing moves until the first branch
      if (!seen_branch && !branch) begin
        check_value("idle instr_valid", 32'd0, 32'(instr_valid));
        check_value("idle bus_req", 32'd0, 32'(bus_req));
      end
      // Bus request rules
      if (bus_req) begin
        check_value("bus addr alignment", 32'd0, 32'(bus_req_data.addr[1:0]));
        if (!fetch_enable && !branch && !branch_pending) begin
          errors++;
          $display("Bus request at %0t while fetching is off and no branch is pending", $time);
        end
      end
      if (bus_req && bus_gnt) begin
        in_flight++;
      end
      if (bus_rvalid) begin
        in_flight--;
      end
      if (in_flight > MAX_OUTSTANDING) begin
        errors++;
        $display("More than %0d requests outstanding at %0t", MAX_OUTSTANDING, $time);
      end
      // Target held until the bus takes it
      if (branch) begin
        branch_pending = !(bus_req && bus_gnt);
      end else if (bus_req && bus_gnt) begin
        branch_pending = 1'b0;
      end
      // A stalled word must not change
      if (held) begin
        check_value("held instr_valid", 32'd1, 32'(instr_valid));
        check_value("held addr", held_word.addr, instr.addr);
        check_value("held rdata", held_word.rdata, instr.rdata);
        check_value("held err", 32'(held_word.err), 32'(instr.err));
      end
      held      = instr_valid && !instr_ready && !branch;
      held_word = instr;
      // Branch restarts the stream, no transfer in that cycle
      if (branch) begin
        exp_addr    = branch_addr;
        seen_branch = 1'b1;
      end else if (instr_valid && instr_ready) begin
        check_value("word addr", exp_addr, instr.addr);
        check_value("word rdata", exp_addr ^ DATA_KEY, instr.rdata);
        check_value("word err", 32'(exp_addr[31:28] == 4'hF), 32'(instr.err));
        exp_addr = exp_addr + 32'd4;
        words++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    addr_t       target;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    branch       = 1'b0;
    branch_addr  = '0;
    instr_ready  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Enabled but no branch yet, so no request
    fetch_enable = 1'b1;
    instr_ready  = 1'b1;
    repeat (4) @(negedge clk);

    // Plain stream, decode always ready
    jump_to(32'h0000_1000);
    while (words < 40) begin
      @(negedge clk);
    end

    // Back-pressure across the top of memory, err region then wrap to zero
    jump_to(32'hFFFF_FF80);
    while (words < 120) begin
      r = next_rand();
      instr_ready = r[31];
      @(negedge clk);
    end

    // Random branches, stalls and enable gaps
    while (words < NUM_WORDS) begin
      r = next_rand();
      instr_ready  = (r[31:30] != 2'b00);
      fetch_enable = (r[29:27] != 3'b000);
      if (!branch && r[26:23] == 4'd0) begin
        target      = next_rand();
        target[1:0] = 2'b00;
        if (r[22:21] == 2'b00) begin
          target[31:28] = 4'hF;
        end
        branch      = 1'b1;
        branch_addr = target;
      end else begin
        branch = 1'b0;
      end
      @(negedge clk);
    end
    branch = 1'b0;
    repeat (2) @(negedge clk);

    $display("Checked %0d words, %0d errors", words, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d of %0d words delivered", TIMEOUT_NS, words, NUM_WORDS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- ifetch.f
common/ifetch_pkg.sv
prefetch/ifetch_prefetch_ctrl.sv
prefetch/ifetch_instr_fifo.sv
source/ifetch_obi_adapter.sv
source/ifetch_top.sv
test/tb_ifetch_mem.sv
test/tb_ifetch.sv

//--- Makefile
# Verilator build and run of the ifetch testbench
LOG := sim.log

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_ifetch -f ifetch.f
	./obj_dir/Vtb_ifetch | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
